// ==== Makefile ====
# Verilator build and run for the ULA testbench

VERILATOR ?= verilator
TOP       ?= tb_ula
FILELIST  ?= ula.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== common/ula_pkg.sv ====
// *********************************************************************
// ULA shared definitions
// Word and float field types, opcodes and the stream payloads
// *********************************************************************

package ula_pkg;

	// *****************************************************************
	// Sizes
	// *****************************************************************

	localparam int NUBITS = 32;  // Operand and result width
	localparam int NBMANT = 23;  // Mantissa without hidden bit
	localparam int NBEXPO = 8;   // Two's complement exponent

	typedef logic signed [NUBITS-1:0] ula_word_t;

	// Float value is +-mant * 2^expo
	typedef struct packed {
		logic                     sign;
		logic signed [NBEXPO-1:0] expo;
		logic        [NBMANT-1:0] mant;
	} ula_float_t;

	// *****************************************************************
	// Opcodes
	// *****************************************************************

	// Gaps in the numbering are unused codes
	typedef enum logic [5:0] {
		LOD   = 6'd1,   // Pass a
		ADD   = 6'd2,
		F_ADD = 6'd3,
		MLT   = 6'd4,
		F_MLT = 6'd5,
		F_NEG = 6'd13,  // Of b
		F_ABS = 6'd17,  // Of b
		I2F   = 6'd25,  // Of b
		AND   = 6'd29,
		ORR   = 6'd30,
		XOR   = 6'd31,
		INV   = 6'd32,  // ~b
		LAN   = 6'd34,
		LOR   = 6'd35,
		LIN   = 6'd36,  // !b
		LES   = 6'd38,
		F_LES = 6'd39,
		GRE   = 6'd40,
		F_GRE = 6'd41,
		EQU   = 6'd42,
		SHL   = 6'd43,
		SHR   = 6'd44,
		SRS   = 6'd45   // Arithmetic right
	} ula_op_t;

	// 70-bit request into the ALU
	typedef struct packed {
		ula_op_t   op;
		ula_word_t a;
		ula_word_t b;
	} ula_req_t;

	// 38-bit result out of the ALU
	typedef struct packed {
		ula_word_t result;
		ula_op_t   op;      // Op that produced it
	} ula_res_t;

	// Float unit owns the result
	function automatic logic op_is_float(input ula_op_t op);
		case (op)
			F_ADD, F_MLT, I2F, F_NEG, F_ABS, F_LES, F_GRE: return 1'b1;
			default: return 1'b0;
		endcase
	endfunction

	// Float result goes through the normalizer
	function automatic logic op_needs_norm(input ula_op_t op);
		return (op == F_ADD) || (op == F_MLT) || (op == I2F);
	endfunction

	// Condition as a 1 or 0 word
	function automatic ula_word_t bool_word(input logic c);
		return {{(NUBITS-1){1'b0}}, c};
	endfunction

endpackage

// ==== tb/ula_model.svh ====
// *********************************************************************
// ULA reference model
// Expected result word for any request, integer and float rules
// *********************************************************************

`ifndef ULA_MODEL_SVH
`define ULA_MODEL_SVH

// Walk the mantissa up until bit 22 is set
function automatic logic [31:0] model_norm(input logic s, input logic [7:0] e,
		input logic [22:0] m);
	logic [7:0]  ex;
	logic [22:0] mt;
	ex = e;
	mt = m;
	if (mt == 23'd0)
		return 32'h4000_0000;  // Canonical zero
	while (!mt[22]) begin
		mt = mt << 1;
		ex = ex - 8'd1;  // Wraps like the hardware
	end
	return {s, ex, mt};
endfunction

// Signed mantissas brought to the larger exponent
function automatic void model_align(input logic [31:0] a, input logic [31:0] b,
		output longint sa, output longint sb, output logic [7:0] e_big);
	int     ea;
	int     eb;
	longint ma;
	longint mb;
	ea = int'($signed(a[30:23]));
	eb = int'($signed(b[30:23]));
	ma = longint'(a[22:0]);
	mb = longint'(b[22:0]);
	if (ea < eb) begin
		ma = ma >> (eb - ea);  // Gaps past 22 leave zero
		e_big = b[30:23];
	end else begin
		mb = mb >> (ea - eb);
		e_big = a[30:23];
	end
	sa = a[31] ? -ma : ma;
	sb = b[31] ? -mb : mb;
endfunction

function automatic ula_word_t model_result(input ula_req_t r);
	longint      sa;
	longint      sb;
	longint      t;
	logic [7:0]  e_big;
	logic [22:0] v;
	if (op_is_float(r.op)) begin
		model_align(r.a, r.b, sa, sb, e_big);
		case (r.op)
			F_ADD: begin
				t = sa + sb;
				// Magnitude bits 23..1, exponent one up for the carry
				return model_norm(t < 0, e_big + 8'd1, 23'((t < 0 ? -t : t) >> 1));
			end
			F_MLT: begin
				t = longint'(r.a[22:0]) * longint'(r.b[22:0]);
				return model_norm(r.a[31] ^ r.b[31], r.a[30:23] + r.b[30:23] + 8'd23,
					23'(t >> 23));
			end
			I2F: begin
				v = r.b[22:0];
				return model_norm(v[22], 8'd0, v[22] ? ~v + 23'd1 : v);
			end
			F_NEG:   return {~r.b[31], r.b[30:0]};
			F_ABS:   return {1'b0, r.b[30:0]};
			F_LES:   return (sa < sb) ? 32'sd1 : 32'sd0;
			F_GRE:   return (sa > sb) ? 32'sd1 : 32'sd0;
			default: return '0;
		endcase
	end
	case (r.op)
		LOD:     return r.a;
		ADD:     return r.a + r.b;
		MLT:     return ula_word_t'(longint'($signed(r.a)) * longint'($signed(r.b)));
		AND:     return r.a & r.b;
		ORR:     return r.a | r.b;
		XOR:     return r.a ^ r.b;
		INV:     return ~r.b;
		SHL:     return r.a << r.b[4:0];
		SHR:     return ula_word_t'($unsigned(r.a) >> r.b[4:0]);
		SRS:     return $signed(r.a) >>> r.b[4:0];
		LES:     return ($signed(r.a) < $signed(r.b)) ? 32'sd1 : 32'sd0;
		GRE:     return ($signed(r.a) > $signed(r.b)) ? 32'sd1 : 32'sd0;
		EQU:     return (r.a == r.b) ? 32'sd1 : 32'sd0;
		LAN:     return (r.a != 0 && r.b != 0) ? 32'sd1 : 32'sd0;
		LOR:     return (r.a != 0 || r.b != 0) ? 32'sd1 : 32'sd0;
		LIN:     return (r.b == 0) ? 32'sd1 : 32'sd0;
		default: return '0;
	endcase
endfunction

`endif

// ==== tb/tb_ula.sv ====
// *********************************************************************
// ULA testbench
// Random requests against a reference model under back-pressure
// *********************************************************************

`timescale 1ns/1ps

module tb_ula import ula_pkg::*; ();

	localparam int N_INT   = 400;
	localparam int N_FLOAT = 400;
	localparam int N_MIXED = 300;
	localparam int N_TOTAL = N_INT + N_FLOAT + 1 + N_MIXED;
	localparam int WATCHDOG_CYCLES = N_TOTAL * 4 + 200;
	localparam logic [31:0] FLOAT_ZERO = 32'h4000_0000;

	localparam ula_op_t INT_OPS [16] = '{LOD, ADD, MLT, AND, ORR, XOR, INV, SHL,
		SHR, SRS, LES, GRE, EQU, LAN, LOR, LIN};
	localparam ula_op_t FLOAT_OPS [7] = '{F_ADD, F_MLT, I2F, F_NEG, F_ABS, F_LES, F_GRE};

	logic     clk;
	logic     rst;
	logic     in_valid;
	logic     in_ready;
	ula_req_t in_req;
	logic     out_valid;
	logic     out_ready;
	ula_res_t out_res;

	ula_res_t expected [$];  // In request order
	int       errors;
	int       checks;
	int       norm_checks;
	int       norm_errors;
	logic     stalled;       // Output held back last edge
	ula_res_t held;

	`include "ula_model.svh"

	ula u_ula (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.in_ready  (in_ready),
		.in_req    (in_req),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_res   (out_res)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout: the run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Done: errors found");
		$finish;
	end

	// *****************************************************************
	// Stimulus
	// *****************************************************************

	function automatic ula_word_t random_float();
		logic        s;
		logic [7:0]  e;
		logic [22:0] m;
		s = 1'($urandom_range(1, 0));
		if ($urandom_range(1, 0) == 1)
			e = 8'($urandom_range(16, 0) - 8);  // Near zero
		else
			e = 8'($urandom);  // Full range for wide gaps
		case ($urandom_range(7, 0))
			0:       m = '0;
			1:       m = 23'($urandom_range(255, 1));  // Needs a long shift
			default: m = 23'($urandom);
		endcase
		return {s, e, m};
	endfunction

	// Mode 0 is integer, 1 float and 2 mixed
	function automatic ula_req_t random_req(input int mode);
		ula_req_t r;
		logic     use_float;
		use_float = (mode == 1) || (mode == 2 && $urandom_range(1, 0) == 1);
		if (use_float) begin
			r.op = FLOAT_OPS[$urandom_range(6, 0)];
			r.a  = random_float();
			r.b  = random_float();
		end else begin
			r.op = INT_OPS[$urandom_range(15, 0)];
			r.a  = $urandom;
			r.b  = ($urandom_range(3, 0) == 0) ? r.a : $urandom;  // Hits EQU
			if ($urandom_range(7, 0) == 0)
				r.b = '0;
		end
		return r;
	endfunction

	task automatic drain();
		while (expected.size() != 0 || out_valid) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Send n requests and hold each until taken
	task automatic stream(input int n, input int mode, input logic rand_valid,
			input logic rand_ready);
		int   sent;
		logic accepted;
		sent = 0;
		while (sent < n) begin
			if (!in_valid && (!rand_valid || $urandom_range(1, 0) == 1)) begin
				in_valid = 1'b1;
				in_req   = random_req(mode);
			end
			out_ready = rand_ready ? 1'($urandom_range(1, 0)) : 1'b1;
			@(posedge clk);
			accepted = in_valid && in_ready;
			#1;
			if (accepted) begin
				sent++;
				in_valid = 1'b0;
			end
		end
		out_ready = 1'b1;
		drain();
	endtask

	// *****************************************************************
	// Checks
	// *****************************************************************

	function automatic logic normalized_op(input ula_op_t op);
		return op inside {F_ADD, F_MLT, I2F};
	endfunction

	task automatic check_output();
		ula_res_t exp_res;
		if (expected.size() == 0) begin
			errors++;
			$display("A result came out at %0t with no request outstanding", $time);
			return;
		end
		exp_res = expected.pop_front();
		checks++;
		if (out_res.op !== exp_res.op) begin
			errors++;
			$display("Fail at %0t: out_res.op expected %s, got %s", $time,
				exp_res.op.name(), out_res.op.name());
		end
		if (out_res.result !== exp_res.result) begin
			errors++;
			$display("Fail at %0t: out_res.result expected %h, got %h (%s)", $time,
				exp_res.result, out_res.result, exp_res.op.name());
		end
		if (normalized_op(out_res.op)) begin
			norm_checks++;
			if (!out_res.result[22] && out_res.result !== FLOAT_ZERO) begin
				errors++;
				norm_errors++;
				$display("Result %h of %s at %0t is neither normalized nor zero",
					out_res.result, out_res.op.name(), $time);
			end
		end
	endtask

	// Scoreboard sampled at the transfer edge
	always @(posedge clk) begin
		ula_res_t exp_res;
		if (rst) begin
			stalled = 1'b0;
		end else begin
			if (stalled) begin
				checks++;
				if (!out_valid || out_res !== held) begin
					errors++;
					$display("Fail at %0t: out_res expected %h, got %h while stalled",
						$time, held, out_res);
				end
			end
			if (in_valid && in_ready) begin
				exp_res.result = model_result(in_req);
				exp_res.op     = in_req.op;
				expected.push_back(exp_res);
			end
			if (out_valid && out_ready)
				check_output();
			stalled = out_valid && !out_ready;
			held    = out_res;
		end
	end

	task automatic check_reset();
		@(posedge clk);
		checks++;
		if (out_valid !== 1'b0) begin
			errors++;
			$display("Fail at %0t: out_valid expected 0, got %b", $time, out_valid);
		end
		if (in_ready !== 1'b1) begin
			errors++;
			$display("Fail at %0t: in_ready expected 1, got %b", $time, in_ready);
		end
		#1;
	endtask

	// Lone request shows out_valid from the edge after acceptance
	task automatic check_latency();
		out_ready = 1'b1;
		in_valid  = 1'b1;
		in_req    = random_req(2);
		@(posedge clk);
		while (!in_ready)
			@(posedge clk);
		#1;
		in_valid = 1'b0;
		@(posedge clk);
		checks++;
		if (out_valid !== 1'b0) begin
			errors++;
			$display("Fail at %0t: out_valid expected 0, got %b", $time, out_valid);
		end
		@(posedge clk);
		checks++;
		if (out_valid !== 1'b1) begin
			errors++;
			$display("Fail at %0t: out_valid expected 1, got %b", $time, out_valid);
		end
		#1;
		drain();
	endtask

	task automatic print_test_result(input string name, input int start_err);
		$display("Test %s finished with %0d errors", name, errors - start_err);
	endtask

	// *****************************************************************
	// Test sequence
	// *****************************************************************

	initial begin
		int start_err;
		void'($urandom(58));
		errors      = 0;
		checks      = 0;
		norm_checks = 0;
		norm_errors = 0;
		stalled     = 1'b0;
		rst         = 1'b1;
		in_valid    = 1'b0;
		in_req      = '0;
		out_ready   = 1'b1;
		repeat (8) @(posedge clk);
		#1;
		rst = 1'b0;

		start_err = errors;
		check_reset();
		print_test_result("reset", start_err);

		start_err = errors;
		stream(N_INT, 0, 1'b0, 1'b0);
		print_test_result("integer_ops", start_err);

		start_err = errors;
		stream(N_FLOAT, 1, 1'b0, 1'b0);
		print_test_result("float_ops", start_err);

		start_err = errors;
		check_latency();
		print_test_result("latency", start_err);

		start_err = errors;
		stream(N_MIXED, 2, 1'b1, 1'b1);
		print_test_result("back_pressure", start_err);

		$display("Test normalization finished with %0d errors over %0d results",
			norm_errors, norm_checks);
		$display("Summary: %0d checks, %0d errors, %0d results missing",
			checks, errors, expected.size());
		if (errors == 0 && expected.size() == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule

// ==== ula.f ====
+incdir+tb
common/ula_pkg.sv
ula/ula_norm.sv
ula/ula_int.sv
ula/ula_float.sv
verilog/ula_pipe_reg.sv
verilog/ula.sv
tb/tb_ula.sv

// ==== ula/ula_float.sv ====
// *********************************************************************
// ULA float unit
// Alignment, add, multiply, int to float, negate, abs and compares
// *********************************************************************

`timescale 1ns/1ps

module ula_float import ula_pkg::*; #(
	parameter int MAN = NBMANT,
	parameter int EXP = NBEXPO
) (
	input  ula_op_t   op,
	input  ula_word_t a,
	input  ula_word_t b,
	output ula_word_t result
);

	localparam int W = 1 + EXP + MAN;

	// Operand fields
	logic                  s_a, s_b;
	logic signed [EXP-1:0] e_a, e_b;
	logic        [MAN-1:0] m_a, m_b;

	assign {s_a, e_a, m_a} = a;
	assign {s_b, e_b, m_b} = b;

	// *****************************************************************
	// Exponent alignment, shared by add and compares
	// *****************************************************************

	logic signed [EXP:0]   e_diff;   // e_a - e_b, no overflow
	logic                  a_small;  // a has the smaller exponent
	logic        [EXP:0]   sh_a, sh_b;
	logic signed [EXP-1:0] e_big;
	logic        [MAN-1:0] m_a_al, m_b_al;
	logic signed [MAN:0]   sm_a, sm_b;  // Signed aligned mantissas

	assign e_diff  = e_a - e_b;
	assign a_small = e_diff[EXP];
	assign sh_a    = a_small ? -e_diff : '0;
	assign sh_b    = a_small ? '0 : e_diff;
	assign e_big   = a_small ? e_b : e_a;  // Larger exponent is kept

	assign m_a_al = m_a >> sh_a;  // Wide gaps shift to zero
	assign m_b_al = m_b >> sh_b;

	assign sm_a = s_a ? -{1'b0, m_a_al} : {1'b0, m_a_al};
	assign sm_b = s_b ? -{1'b0, m_b_al} : {1'b0, m_b_al};

	// *****************************************************************
	// Unnormalized results
	// *****************************************************************

	logic signed [MAN+1:0]   sum;      // One more bit for the carry
	logic        [MAN+1:0]   sum_mag;
	logic        [W-1:0]     add_word;
	logic        [2*MAN-1:0] prod;
	logic        [EXP-1:0]   e_prod;
	logic        [W-1:0]     mlt_word;
	logic        [MAN-1:0]   i_raw, i_mag;
	logic        [W-1:0]     i2f_word;

	// F_ADD, drop the low bit and bump the exponent to fit the carry
	assign sum      = sm_a + sm_b;
	assign sum_mag  = sum[MAN+1] ? -sum : sum;
	assign add_word = {sum[MAN+1], e_big + EXP'(1), sum_mag[MAN:1]};

	// F_MLT keeps the top half, exponent wraps
	// Zero product becomes the canonical zero in the normalizer
	assign prod     = m_a * m_b;
	assign e_prod   = e_a + e_b + EXP'(MAN);
	assign mlt_word = {s_a ^ s_b, e_prod, prod[2*MAN-1:MAN]};

	// I2F of the low mantissa-wide bits of b
	assign i_raw    = b[MAN-1:0];
	assign i_mag    = i_raw[MAN-1] ? -i_raw : i_raw;
	assign i2f_word = {i_raw[MAN-1], {EXP{1'b0}}, i_mag};

	// *****************************************************************
	// Shared normalizer
	// *****************************************************************

	logic [W-1:0] pre_norm, post_norm;

	always_comb begin
		case (op)
			F_ADD:   pre_norm = add_word;
			F_MLT:   pre_norm = mlt_word;
			default: pre_norm = i2f_word;  // I2F
		endcase
	end

	ula_norm #(
		.MAN (MAN),
		.EXP (EXP)
	) u_norm (
		.in_word  (pre_norm),
		.out_word (post_norm)
	);

	// *****************************************************************
	// Result select
	// *****************************************************************

	always_comb begin
		if (op_needs_norm(op)) begin
			result = post_norm;
		end else begin
			case (op)
				F_NEG:   result = {~b[W-1], b[W-2:0]};  // Flip sign
				F_ABS:   result = {1'b0, b[W-2:0]};     // Clear sign
				F_LES:   result = bool_word(sm_a < sm_b);
				F_GRE:   result = bool_word(sm_a > sm_b);
				default: result = '0;  // Integer ops
			endcase
		end
	end

endmodule

// ==== ula/ula_int.sv ====
// *********************************************************************
// ULA integer unit
// Arithmetic, logic, shift, condition and compare ops on signed words
// *********************************************************************

`timescale 1ns/1ps

module ula_int import ula_pkg::*; (
	input  ula_op_t   op,
	input  ula_word_t a,
	input  ula_word_t b,
	output ula_word_t result
);

	localparam int SHW = $clog2(NUBITS);  // Shift amount bits

	logic      [SHW-1:0] shamt;    // Low bits of b only
	logic                a_true;   // a as a condition
	logic                b_true;   // b as a condition
	ula_word_t           sum;
	ula_word_t           prod;

	assign shamt  = b[SHW-1:0];
	assign a_true = (a != '0);
	assign b_true = (b != '0);

	// *****************************************************************
	// Arithmetic
	// *****************************************************************

	assign sum  = a + b;
	assign prod = a * b;  // Low half of the product

	// *****************************************************************
	// Result select
	// *****************************************************************

	always_comb begin
		case (op)
			LOD: result = a;
			ADD: result = sum;
			MLT: result = prod;

			// Bitwise
			AND: result = a & b;
			ORR: result = a | b;
			XOR: result = a ^ b;
			INV: result = ~b;

			// Shifts
			SHL: result = a << shamt;
			SHR: result = a >> shamt;   // Zero fill
			SRS: result = a >>> shamt;  // Sign fill

			// Conditions give 1 or 0
			LAN: result = bool_word(a_true && b_true);
			LOR: result = bool_word(a_true || b_true);
			LIN: result = bool_word(!b_true);

			// Signed compares
			LES: result = bool_word(a < b);
			GRE: result = bool_word(a > b);
			EQU: result = bool_word(a == b);

			default: result = '0;  // Float ops, not selected by top
		endcase
	end

endmodule

// ==== ula/ula_norm.sv ====
// *********************************************************************
// ULA float normalizer
// Shifts the mantissa left until its top bit is set
// *********************************************************************

`timescale 1ns/1ps

module ula_norm import ula_pkg::*; #(
	parameter int MAN = NBMANT,
	parameter int EXP = NBEXPO
) (
	input  logic [EXP+MAN:0] in_word,
	output logic [EXP+MAN:0] out_word
);

	logic                  in_sign;
	logic signed [EXP-1:0] in_expo;
	logic        [MAN-1:0] in_mant;
	logic        [EXP-1:0] lz [MAN-1];  // Leading zero chain
	logic        [EXP-1:0] shamt;

	assign {in_sign, in_expo, in_mant} = in_word;

	// *****************************************************************
	// Leading zero count
	// *****************************************************************

	// Each link looks at one more top bit and counts if all are zero
	assign lz[0] = in_mant[MAN-1] ? '0 : EXP'(1);

	for (genvar i = 1; i < MAN-1; i++) begin : g_lz
		assign lz[i] = (in_mant[MAN-1 -: i+1] == '0) ? EXP'(i+1) : lz[i-1];
	end

	assign shamt = lz[MAN-2];  // At most MAN-1, bit 0 goes to the top

	// *****************************************************************
	// Output
	// *****************************************************************

	// Zero mantissa maps to the canonical zero, exponent most negative
	assign out_word = (in_mant == '0) ?
		{1'b0, 1'b1, {(EXP+MAN-1){1'b0}}} :
		{in_sign, in_expo - shamt, in_mant << shamt};

	always_comb begin
		if (in_mant != '0)
			a_top_set: assert final (out_word[MAN-1]);
	end

endmodule

// ==== verilog/ula.sv ====
// *********************************************************************
// ULA streaming top level
// Request stage, integer and float units, result stage
// *********************************************************************

`timescale 1ns/1ps

module ula import ula_pkg::*; #(
	parameter int MAN = NBMANT,
	parameter int EXP = NBEXPO
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     in_valid,
	output logic     in_ready,
	input  ula_req_t in_req,
	output logic     out_valid,
	input  logic     out_ready,
	output ula_res_t out_res
);

	ula_req_t  req_q;      // Held request
	logic      req_valid;
	logic      req_ready;  // Result stage can take it
	ula_word_t int_res;
	ula_word_t float_res;
	ula_res_t  res_d;

	// *****************************************************************
	// Request stage
	// *****************************************************************

	ula_pipe_reg #(
		.payload_t (ula_req_t)
	) u_req_stage (
		.clk        (clk),
		.rst        (rst),
		.up_valid   (in_valid),
		.up_ready   (in_ready),
		.up_data    (in_req),
		.down_valid (req_valid),
		.down_ready (req_ready),
		.down_data  (req_q)
	);

	// *****************************************************************
	// Units, both see every request
	// *****************************************************************

	ula_int u_int (
		.op     (req_q.op),
		.a      (req_q.a),
		.b      (req_q.b),
		.result (int_res)
	);

	ula_float #(
		.MAN (MAN),
		.EXP (EXP)
	) u_float (
		.op     (req_q.op),
		.a      (req_q.a),
		.b      (req_q.b),
		.result (float_res)
	);

	assign res_d.result = op_is_float(req_q.op) ? float_res : int_res;
	assign res_d.op     = req_q.op;  // Tag for the consumer

	// *****************************************************************
	// Result stage
	// *****************************************************************

	ula_pipe_reg #(
		.payload_t (ula_res_t)
	) u_res_stage (
		.clk        (clk),
		.rst        (rst),
		.up_valid   (req_valid),
		.up_ready   (req_ready),
		.up_data    (res_d),
		.down_valid (out_valid),
		.down_ready (out_ready),
		.down_data  (out_res)
	);

endmodule

// ==== verilog/ula_pipe_reg.sv ====
// *********************************************************************
// ULA pipeline register
// One-entry valid/ready stage for any payload type
// *********************************************************************

`timescale 1ns/1ps

module ula_pipe_reg #(
	parameter type payload_t = logic
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     up_valid,
	output logic     up_ready,
	input  payload_t up_data,
	output logic     down_valid,
	input  logic     down_ready,
	output payload_t down_data
);

	logic     full;    // Entry held
	payload_t data_q;
	logic     load;

	// Take new data when empty or when the entry leaves this cycle
	assign up_ready = !full || down_ready;
	assign load     = up_valid && up_ready;

	always_ff @(posedge clk) begin
		if (rst)
			full <= 1'b0;
		else if (load)
			full <= 1'b1;  // Refill, also on pass-through
		else if (down_ready)
			full <= 1'b0;  // Drained, nothing new
	end

	always_ff @(posedge clk) begin
		if (load)
			data_q <= up_data;
	end

	assign down_valid = full;
	assign down_data  = data_q;

	// Stalled entry must not move
	a_hold_stall: assert property (@(posedge clk) disable iff (rst)
		down_valid && !down_ready |=> down_valid && $stable(down_data));

	a_empty_after_rst: assert property (@(posedge clk) rst |=> !down_valid);

endmodule
